/* common/cache_pkg.sv */
package cache_pkg;

    // ******************************
    // Widths and address split
    // ******************************

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int SET_BITS  = 4;
    localparam int WORD_BITS = 2;
    // Two byte-offset bits below the word select.
    localparam int TAG_BITS  = ADDR_W - SET_BITS - WORD_BITS - 2;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [SET_BITS-1:0]  index_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    // ******************************
    // APB request and response
    // ******************************

    typedef struct packed {
        addr_t paddr;
        logic  pwrite;
        data_t pwdata;
        logic  psel;
        logic  penable;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // ******************************
    // Way commands
    // ******************************

    // Same lookup goes to every way.
    typedef struct packed {
        index_t index;
        word_t  word;
        tag_t   tag;
    } way_lookup_t;

    typedef struct packed {
        logic  wr_data;
        data_t wdata;
        word_t word;
        logic  install;
        logic  set_dirty;
    } way_write_t;

endpackage

/* cache/cache_way.sv */
module cache_way (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::way_lookup_t i_lookup,
    input  cache_pkg::way_write_t  i_write,
    output logic                   o_hit,
    output logic                   o_valid,
    output logic                   o_dirty,
    output cache_pkg::tag_t        o_tag,
    output cache_pkg::data_t       o_rdata
);
    import cache_pkg::*;

    localparam int NSETS  = 2 ** SET_BITS;
    localparam int NWORDS = 2 ** WORD_BITS;

    logic [NSETS-1:0] valid_q;
    logic [NSETS-1:0] dirty_q;
    tag_t             tag_q  [NSETS];
    data_t            data_q [NSETS][NWORDS];

    index_t idx;

    assign idx = i_lookup.index;

    // Line state, cleared by reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (i_write.install) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end else if (i_write.set_dirty) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    // Tag and data arrays.
    always_ff @(posedge clk) begin
        if (i_write.install) begin
            tag_q[idx] <= i_lookup.tag;
        end
        if (i_write.wr_data) begin
            data_q[idx][i_write.word] <= i_write.wdata;
        end
    end

    // Asynchronous read at the looked-up set.
    assign o_valid = valid_q[idx];
    assign o_dirty = dirty_q[idx];
    assign o_tag   = tag_q[idx];
    assign o_rdata = data_q[idx][i_lookup.word];
    assign o_hit   = valid_q[idx] && (tag_q[idx] == i_lookup.tag);

endmodule

/* cache/cache_lru.sv */
module cache_lru #(
    parameter int NUM_WAYS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cache_pkg::index_t           i_index,
    input  logic [NUM_WAYS-1:0]         i_valid,
    input  logic                        i_touch,
    input  logic [$clog2(NUM_WAYS)-1:0] i_touch_way,
    output logic [$clog2(NUM_WAYS)-1:0] o_victim
);
    import cache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int NSETS = 2 ** SET_BITS;

    logic [WAY_W-1:0] age_q [NSETS][NUM_WAYS];
    logic [WAY_W-1:0] touch_age;
    logic [WAY_W-1:0] oldest_age;
    logic             found_free;

    assign touch_age = age_q[i_index][i_touch_way];

    // Touched way becomes youngest. Ways not older than it age by one,
    // so ties left over from reset resolve into distinct ages.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NSETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (i_touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_W'(w) == i_touch_way) begin
                    age_q[i_index][w] <= '0;
                end else if (age_q[i_index][w] <= touch_age) begin
                    age_q[i_index][w] <= age_q[i_index][w] + 1'b1;
                end
            end
        end
    end

    // Lowest free way first, then the oldest.
    always_comb begin
        found_free = 1'b0;
        oldest_age = '0;
        o_victim   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!i_valid[w] && !found_free) begin
                found_free = 1'b1;
                o_victim   = WAY_W'(w);
            end
        end
        if (!found_free) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (age_q[i_index][w] > oldest_age) begin
                    oldest_age = age_q[i_index][w];
                    o_victim   = WAY_W'(w);
                end
            end
        end
    end

endmodule

/* cache/cache_ctrl.sv */
module cache_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  cache_pkg::apb_req_t                  i_cpu,
    output cache_pkg::apb_rsp_t                  o_cpu,
    output cache_pkg::apb_req_t                  o_mem,
    input  cache_pkg::apb_rsp_t                  i_mem,
    output cache_pkg::way_lookup_t               o_lookup,
    output cache_pkg::way_write_t [NUM_WAYS-1:0] o_write,
    input  logic [NUM_WAYS-1:0]                  i_hit,
    input  logic [NUM_WAYS-1:0]                  i_valid,
    input  logic [NUM_WAYS-1:0]                  i_dirty,
    input  cache_pkg::tag_t [NUM_WAYS-1:0]       i_tag,
    input  cache_pkg::data_t [NUM_WAYS-1:0]      i_rdata,
    output logic                                 o_lru_touch,
    output logic [$clog2(NUM_WAYS)-1:0]          o_lru_way,
    input  logic [$clog2(NUM_WAYS)-1:0]          i_victim
);
    import cache_pkg::*;

    localparam int    WAY_W     = $clog2(NUM_WAYS);
    localparam word_t LAST_WORD = '1;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } state_t;

    state_t           state_q;
    logic [WAY_W-1:0] way_q;
    word_t            cnt_q;
    logic             penable_q;
    logic             pready_q;
    logic             pslverr_q;

    addr_t addr_q;
    logic  write_q;
    data_t wdata_q;
    data_t rdata_q;

    index_t           req_index;
    tag_t             req_tag;
    word_t            req_word;
    logic             aligned;
    logic             any_hit;
    logic             beat_done;
    logic             cpu_setup;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] cmd_way;
    way_write_t       cmd;

    assign req_word  = addr_q[2 +: WORD_BITS];
    assign req_index = addr_q[2 + WORD_BITS +: SET_BITS];
    assign req_tag   = addr_q[ADDR_W-1 -: TAG_BITS];
    assign aligned   = (addr_q[1:0] == 2'b00);
    assign any_hit   = |i_hit;
    assign beat_done = penable_q && i_mem.pready;
    assign cpu_setup = i_cpu.psel && !i_cpu.penable;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    // ******************************
    // Control FSM
    // ******************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            way_q     <= '0;
            cnt_q     <= '0;
            penable_q <= 1'b0;
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cpu_setup) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!aligned) begin
                        pslverr_q <= 1'b1;
                        pready_q  <= 1'b1;
                        state_q   <= RESPOND;
                    end else if (any_hit) begin
                        pready_q <= 1'b1;
                        state_q  <= RESPOND;
                    end else begin
                        // Miss. Victim dirty means write-back first.
                        way_q   <= i_victim;
                        cnt_q   <= '0;
                        state_q <= (i_valid[i_victim] && i_dirty[i_victim]) ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK, REFILL: begin
                    if (!penable_q) begin
                        penable_q <= 1'b1;
                    end else if (i_mem.pready) begin
                        penable_q <= 1'b0;
                        cnt_q     <= cnt_q + 1'b1;
                        if (cnt_q == LAST_WORD) begin
                            // Refilled line is looked up again and then hits.
                            state_q <= (state_q == WRITEBACK) ? REFILL : LOOKUP;
                        end
                    end
                end
                RESPOND: begin
                    pready_q  <= 1'b0;
                    pslverr_q <= 1'b0;
                    state_q   <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request and read data registers.
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_setup) begin
            addr_q  <= i_cpu.paddr;
            write_q <= i_cpu.pwrite;
            wdata_q <= i_cpu.pwdata;
        end
        if (state_q == LOOKUP) begin
            rdata_q <= i_rdata[hit_way];
        end
    end

    assign o_cpu.prdata  = rdata_q;
    assign o_cpu.pready  = pready_q;
    assign o_cpu.pslverr = pslverr_q;

    // ******************************
    // Ways, LRU and memory port
    // ******************************

    assign o_lookup.index = req_index;
    assign o_lookup.tag   = req_tag;
    assign o_lookup.word  = (state_q == WRITEBACK) ? cnt_q : req_word;

    always_comb begin
        cmd     = '0;
        cmd_way = way_q;
        if (state_q == LOOKUP) begin
            cmd_way = hit_way;
            if (aligned && any_hit && write_q) begin
                cmd.wr_data   = 1'b1;
                cmd.wdata     = wdata_q;
                cmd.word      = req_word;
                cmd.set_dirty = 1'b1;
            end
        end else if (state_q == REFILL && beat_done) begin
            cmd.wr_data = 1'b1;
            cmd.wdata   = i_mem.prdata;
            cmd.word    = cnt_q;
            cmd.install = (cnt_q == LAST_WORD);
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            o_write[w] = (cmd_way == WAY_W'(w)) ? cmd : '0;
        end
    end

    // One touch per completed aligned access.
    assign o_lru_touch = (state_q == LOOKUP) && aligned && any_hit;
    assign o_lru_way   = hit_way;

    always_comb begin
        o_mem         = '0;
        o_mem.psel    = (state_q == WRITEBACK) || (state_q == REFILL);
        o_mem.penable = penable_q;
        o_mem.pwrite  = (state_q == WRITEBACK);
        if (state_q == WRITEBACK) begin
            o_mem.paddr  = {i_tag[way_q], req_index, cnt_q, 2'b00};
            o_mem.pwdata = i_rdata[way_q];
        end else begin
            o_mem.paddr = {req_tag, req_index, cnt_q, 2'b00};
        end
    end

endmodule

/* verilog/cache_top.sv */
module cache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::apb_req_t i_cpu,
    output cache_pkg::apb_rsp_t o_cpu,
    output cache_pkg::apb_req_t o_mem,
    input  cache_pkg::apb_rsp_t i_mem
);
    import cache_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    way_lookup_t                lookup;
    way_write_t [NUM_WAYS-1:0]  way_wr;
    logic [NUM_WAYS-1:0]        way_hit;
    logic [NUM_WAYS-1:0]        way_valid;
    logic [NUM_WAYS-1:0]        way_dirty;
    tag_t [NUM_WAYS-1:0]        way_tag;
    data_t [NUM_WAYS-1:0]       way_rdata;
    logic                       lru_touch;
    logic [WAY_W-1:0]           lru_way;
    logic [WAY_W-1:0]           victim;

    cache_ctrl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cpu       (i_cpu),
        .o_cpu       (o_cpu),
        .o_mem       (o_mem),
        .i_mem       (i_mem),
        .o_lookup    (lookup),
        .o_write     (way_wr),
        .i_hit       (way_hit),
        .i_valid     (way_valid),
        .i_dirty     (way_dirty),
        .i_tag       (way_tag),
        .i_rdata     (way_rdata),
        .o_lru_touch (lru_touch),
        .o_lru_way   (lru_way),
        .i_victim    (victim)
    );

    cache_lru #(
        .NUM_WAYS (NUM_WAYS)
    ) u_lru (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_index     (lookup.index),
        .i_valid     (way_valid),
        .i_touch     (lru_touch),
        .i_touch_way (lru_way),
        .o_victim    (victim)
    );

    // One storage block per way.
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_lookup (lookup),
            .i_write  (way_wr[w]),
            .o_hit    (way_hit[w]),
            .o_valid  (way_valid[w]),
            .o_dirty  (way_dirty[w]),
            .o_tag    (way_tag[w]),
            .o_rdata  (way_rdata[w])
        );
    end

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic o_clk
);

    // Free-running clock, low at time zero.
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

/* tests/tb_mem.sv */
module tb_mem #(
    parameter cache_pkg::addr_t BASE     = 32'h0004_0000,
    parameter cache_pkg::data_t FILL_KEY = 32'ha5a5_0000,
    parameter int               DEPTH    = 1024
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::apb_req_t i_req,
    input  logic                i_extra_wait,
    output cache_pkg::apb_rsp_t o_rsp,
    output int                  o_rd_beats,
    output int                  o_wr_beats
);
    import cache_pkg::*;

    data_t                      mem [DEPTH];
    logic                       stalled;
    logic [$clog2(DEPTH)-1:0]   slot;

    // Window is aligned to its size, so the low address bits pick the word.
    assign slot = i_req.paddr[2 +: $clog2(DEPTH)];

    // One wait state per beat, two when the extra wait is selected.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rsp      <= '0;
            stalled    <= 1'b0;
            o_rd_beats <= 0;
            o_wr_beats <= 0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= (BASE + addr_t'(i * 4)) ^ FILL_KEY;
            end
        end else if (i_req.psel && i_req.penable) begin
            if (o_rsp.pready) begin
                // Beat completes here.
                o_rsp.pready <= 1'b0;
                stalled      <= 1'b0;
                if (i_req.pwrite) begin
                    mem[slot]  <= i_req.pwdata;
                    o_wr_beats <= o_wr_beats + 1;
                end else begin
                    o_rd_beats <= o_rd_beats + 1;
                end
            end else if (stalled || !i_extra_wait) begin
                o_rsp.pready <= 1'b1;
                o_rsp.prdata <= mem[slot];
            end else begin
                stalled <= 1'b1;
            end
        end
    end

endmodule

/* tests/tb_cache.sv */
module tb_cache;
    import cache_pkg::*;

    localparam int          NWAYS          = 4;
    localparam int          WAY_W          = $clog2(NWAYS);
    localparam int          NSETS          = 16;
    localparam int          N_RANDOM       = 500;
    localparam int          N_SLOW         = 80;
    localparam int          MAX_OPS        = 600;
    localparam int          CYCLES_PER_OP  = 40;
    localparam int          TIMEOUT_CYCLES = MAX_OPS * CYCLES_PER_OP;
    localparam addr_t       MEM_BASE       = 32'h0004_0000;
    localparam data_t       FILL_KEY       = 32'ha5a5_0000;
    localparam logic [31:0] SEED           = 32'h6e11_97b8;

    logic     clk;
    logic     rst_n;
    apb_req_t cpu_req;
    apb_rsp_t cpu_rsp;
    apb_req_t mem_req;
    apb_rsp_t mem_rsp;
    logic     extra_wait;
    int       rd_beats;
    int       wr_beats;

    // Reference model state.
    data_t            mirror    [addr_t];
    logic             ref_valid [NSETS][NWAYS];
    logic             ref_dirty [NSETS][NWAYS];
    tag_t             ref_tag   [NSETS][NWAYS];
    logic [WAY_W-1:0] ref_age   [NSETS][NWAYS];
    logic [ADDR_W:0]  exp_beats [$];
    int               exp_rd_total = 0;
    int               exp_wr_total = 0;

    // Expected response of the access in flight.
    data_t exp_rdata;
    logic  exp_err;
    logic  exp_write;
    logic  exp_fast;

    int          mismatches  = 0;
    int          failures    = 0;
    int          ops         = 0;
    int          cycles      = 0;
    int          wait_cycles = 0;
    logic [31:0] lfsr_q;

    tb_clock #(.PERIOD(4)) clk_gen (.o_clk(clk));

    tb_mem #(
        .BASE     (MEM_BASE),
        .FILL_KEY (FILL_KEY)
    ) mem_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req        (mem_req),
        .i_extra_wait (extra_wait),
        .o_rsp        (mem_rsp),
        .o_rd_beats   (rd_beats),
        .o_wr_beats   (wr_beats)
    );

    cache_top #(
        .NUM_WAYS (NWAYS)
    ) dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .i_cpu (cpu_req),
        .o_cpu (cpu_rsp),
        .o_mem (mem_req),
        .i_mem (mem_rsp)
    );

    // ******************************
    // Helpers and reference model
    // ******************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic data_t mirror_word(input addr_t a);
        if (mirror.exists(a)) begin
            return mirror[a];
        end
        return a ^ FILL_KEY;
    endfunction

    // Lowest free way, else the first way of the highest age.
    function automatic int pick_victim(input index_t idx);
        int v;
        v = -1;
        for (int w = 0; w < NWAYS; w++) begin
            if (!ref_valid[idx][w] && v < 0) begin
                v = w;
            end
        end
        if (v < 0) begin
            v = 0;
            for (int w = 1; w < NWAYS; w++) begin
                if (ref_age[idx][w] > ref_age[idx][v]) begin
                    v = w;
                end
            end
        end
        return v;
    endfunction

    // Touched way becomes youngest. Ways no older than it age by one.
    function automatic void touch_way(input index_t idx, input int way);
        logic [WAY_W-1:0] old;
        old = ref_age[idx][way];
        for (int w = 0; w < NWAYS; w++) begin
            if (w == way) begin
                ref_age[idx][w] = '0;
            end else if (ref_age[idx][w] <= old) begin
                ref_age[idx][w] = ref_age[idx][w] + 1'b1;
            end
        end
    endfunction

    // Expected read data, plus the beats the access must cause.
    function automatic data_t predict(input addr_t a, input logic wr, input data_t wd,
                                      output logic err, output logic hit);
        index_t idx;
        tag_t   tg;
        int     way;
        idx = a[7:4];
        tg  = a[31:8];
        err = (a[1:0] != 2'b00);
        hit = 1'b0;
        if (err) begin
            return '0;
        end
        way = -1;
        for (int w = 0; w < NWAYS; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            way = pick_victim(idx);
            if (ref_valid[idx][way] && ref_dirty[idx][way]) begin
                for (int k = 0; k < 4; k++) begin
                    exp_beats.push_back({1'b1, ref_tag[idx][way], idx, 2'(k), 2'b00});
                end
                exp_wr_total += 4;
            end
            for (int k = 0; k < 4; k++) begin
                exp_beats.push_back({1'b0, tg, idx, 2'(k), 2'b00});
            end
            exp_rd_total += 4;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
            ref_tag[idx][way]   = tg;
        end
        touch_way(idx, way);
        if (wr) begin
            mirror[a] = wd;
            ref_dirty[idx][way] = 1'b1;
        end
        return mirror_word(a);
    endfunction

    // ******************************
    // Stimulus
    // ******************************

    // Called and returns on a falling edge.
    task automatic cpu_access(input addr_t a, input logic wr, input data_t wd);
        logic hit;
        exp_rdata = predict(a, wr, wd, exp_err, hit);
        exp_write = wr;
        exp_fast  = hit || exp_err;
        cpu_req.paddr   = a;
        cpu_req.pwrite  = wr;
        cpu_req.pwdata  = wd;
        cpu_req.psel    = 1'b1;
        cpu_req.penable = 1'b0;
        @(negedge clk);
        cpu_req.penable = 1'b1;
        @(posedge clk);
        while (!cpu_rsp.pready) begin
            @(posedge clk);
        end
        @(negedge clk);
        cpu_req.psel    = 1'b0;
        cpu_req.penable = 1'b0;
        ops++;
    endtask

    task automatic run_random(input int n, input logic slow);
        logic [31:0] bits;
        addr_t       a;
        logic        wr;
        data_t       wd;
        for (int i = 0; i < n; i++) begin
            if (slow) begin
                bits = take_bits(1);
                extra_wait = bits[0];
            end
            // Three tag bits, set and word.
            bits = take_bits(9);
            a    = MEM_BASE + {21'd0, bits[8:0], 2'b00};
            bits = take_bits(1);
            wr   = bits[0];
            wd   = wr ? take_bits(32) : '0;
            cpu_access(a, wr, wd);
        end
        extra_wait = 1'b0;
    endtask

    initial begin
        lfsr_q     = SEED;
        rst_n      = 1'b0;
        cpu_req    = '0;
        extra_wait = 1'b0;
        for (int s = 0; s < NSETS; s++) begin
            for (int w = 0; w < NWAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_age[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle outputs out of reset.
        check_value("cpu pready", 32'(cpu_rsp.pready), 32'd0);
        check_value("cpu pslverr", 32'(cpu_rsp.pslverr), 32'd0);
        check_value("mem psel", 32'(mem_req.psel), 32'd0);
        check_value("mem penable", 32'(mem_req.penable), 32'd0);

        cpu_access(MEM_BASE + 32'h010, 1'b0, '0);

        // Write, read back, then a hit on the same line.
        cpu_access(MEM_BASE + 32'h024, 1'b1, 32'h1234_5678);
        cpu_access(MEM_BASE + 32'h024, 1'b0, '0);
        cpu_access(MEM_BASE + 32'h028, 1'b0, '0);

        // Five tags in set 5, first one dirty.
        cpu_access(MEM_BASE + 32'h054, 1'b1, 32'h5a17_c3e9);
        for (int t = 1; t < 5; t++) begin
            cpu_access(MEM_BASE + addr_t'(t * 256) + 32'h050, 1'b0, '0);
        end
        cpu_access(MEM_BASE + 32'h054, 1'b0, '0);

        // Misaligned accesses, then the word is unchanged.
        cpu_access(MEM_BASE + 32'h025, 1'b0, '0);
        cpu_access(MEM_BASE + 32'h026, 1'b1, 32'h0bad_0bad);
        cpu_access(MEM_BASE + 32'h024, 1'b0, '0);

        run_random(N_RANDOM, 1'b0);
        run_random(N_SLOW, 1'b1);

        check_value("read beat total", rd_beats, exp_rd_total);
        check_value("write beat total", wr_beats, exp_wr_total);
        if (exp_beats.size() != 0) begin
            failures++;
            $display("%0d expected memory beats never happened", exp_beats.size());
        end
        $display("summary: %0d operations, %0d mismatches, %0d other errors",
                 ops, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // ******************************
    // Monitors and timeout
    // ******************************

    // CPU completion against the reference.
    always @(posedge clk) begin
        if (cpu_req.psel && cpu_req.penable) begin
            if (!cpu_rsp.pready) begin
                wait_cycles++;
            end else begin
                check_value("cpu pslverr", 32'(cpu_rsp.pslverr), 32'(exp_err));
                if (!exp_write && !exp_err) begin
                    check_value("cpu prdata", cpu_rsp.prdata, exp_rdata);
                end
                if (exp_fast) begin
                    check_value("cpu wait states", wait_cycles, 32'd1);
                end
                check_value("mem read beats", rd_beats, exp_rd_total);
                check_value("mem write beats", wr_beats, exp_wr_total);
                wait_cycles = 0;
            end
        end
    end

    // Each memory beat against the expected sequence.
    always @(posedge clk) begin
        logic [ADDR_W:0] beat;
        if (mem_req.psel && mem_req.penable && mem_rsp.pready) begin
            if (exp_beats.size() == 0) begin
                failures++;
                $display("memory beat at %h was not expected", mem_req.paddr);
            end else begin
                beat = exp_beats.pop_front();
                check_value("mem pwrite", 32'(mem_req.pwrite), 32'(beat[ADDR_W]));
                check_value("mem paddr", mem_req.paddr, beat[ADDR_W-1:0]);
                if (beat[ADDR_W]) begin
                    check_value("mem pwdata", mem_req.pwdata, mirror_word(beat[ADDR_W-1:0]));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d operations, %0d mismatches",
                     cycles, ops, mismatches);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

/* sources.f */
common/cache_pkg.sv
cache/cache_way.sv
cache/cache_lru.sv
cache/cache_ctrl.sv
verilog/cache_top.sv
tests/tb_clock.sv
tests/tb_mem.sv
tests/tb_cache.sv

/* Makefile */
# Verilator flow for the set-associative cache.

VERILATOR  := verilator
SIM_FLAGS  := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing
TOP        := tb_cache
RTL_TOP    := cache_top
FILELIST   := sources.f
PASS_MSG   := ALL TESTS PASSED
BIN        := obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Pass only if the run prints the pass message.
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
